//--- filelist.f
+incdir+.
fetch_bus_pkg.sv
fetch_ctrl_pkg.sv
fetch_pc_sel.sv
fetch_credit_ctr.sv
fetch_prefetch_fifo.sv
fetch_ctrl_fsm.sv
fetch_if_stage.sv
tb_fetch_if_stage.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_fetch_if_stage
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --timing --assert
LINT_FLAGS ?= -Wall
PASS_MSG   ?= ALL TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# build, run, and fail unless the pass line shows up in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
	  --Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	  echo "$$out"; \
	  echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb_fetch_if_stage.sv
`include "fetch_params.svh"

module tb_fetch_if_stage;
  import fetch_bus_pkg::*;
  import fetch_ctrl_pkg::*;

  localparam int HALF  = 50;  // 100 unit clock period
  localparam int DRV   = 10;  // input skew after the rising edge
  localparam int STALL = 60;  // decode stall length in the credit test
  localparam int LOADS_TOTAL    = 40 + 60 + 30 + 40 + 30;
  localparam int TIMEOUT_CYCLES = LOADS_TOTAL * 20 + STALL + 200;  // 20 cycles per load is loose

  logic        clk = 1'b0;
  logic        rst_n;
  logic        req_i, pc_set_i, halt_if_i, id_ready_i, clear_instr_valid_i;
  pc_mux_e     pc_mux_i;
  exc_pc_mux_e exc_pc_mux_i;
  logic [31:0] boot_addr_i, jump_target_id_i, jump_target_ex_i, mepc_i, depc_i;
  logic [23:0] trap_base_addr_i;
  logic [4:0]  irq_id_i;
  logic [29:0] dm_halt_addr_i;
  fetch_req_t  imem_req_o;
  fetch_rsp_t  imem_rsp_i;
  if_id_t      if_id_o;
  logic        if_busy_o, perf_imiss_o;

  logic [31:0] stim_rng = 32'd93739;
  logic [31:0] mem_rng;
  logic        slow_mem = 1'b0;  // memory speed mode
  logic [31:0] pend[$];          // granted addresses still owed an rvalid
  int          checks = 0;
  int          errors = 0;
  int          loads = 0;        // IF/ID loads seen by the monitor
  int          test_err0, test_load0;
  string       cur_test = "reset";

  fetch_if_stage u_fetch_if_stage (.*);

  always #(HALF) clk = ~clk;

  //////////////////////////////
  // reference model
  //////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // memory content, a hash of the whole address
  function automatic logic [31:0] ref_word(input logic [31:0] addr);
    return xorshift32(xorshift32(addr ^ 32'h6b43_a9b5) + addr);
  endfunction

  function automatic logic [31:0] next_rand();
    stim_rng = xorshift32(stim_rng);
    return stim_rng;
  endfunction

  // where a redirect must land, word aligned
  function automatic logic [31:0] redirect_target(input pc_mux_e mux, input exc_pc_mux_e exc);
    logic [31:0] t;
    case (mux)
      PC_JUMP:   t = jump_target_id_i;
      PC_BRANCH: t = jump_target_ex_i;
      PC_MRET:   t = mepc_i;
      PC_DRET:   t = depc_i;
      PC_EXCEPTION: begin
        case (exc)
          EXC_PC_IRQ: t = {trap_base_addr_i, 8'h00} | (32'(irq_id_i) << 2);  // one word per vector
          EXC_PC_DBD: t = {dm_halt_addr_i, 2'b00};
          default:    t = {trap_base_addr_i, 8'h00};
        endcase
      end
      default:   t = boot_addr_i;
    endcase
    return t & ~32'h3;
  endfunction

  task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %s %s: expected %h actual %h", cur_test, what, exp, act);
    end
  endtask

  //////////////////////////////
  // stimulus helpers
  //////////////////////////////

  task automatic next_cycle();
    @(posedge clk);
    #(DRV);
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    test_err0 = errors;
    test_load0 = loads;
  endtask

  task automatic end_test();
    $display("test %-20s %0d loads, %0d errors", cur_test, loads - test_load0, errors - test_err0);
  endtask

  // one cycle pc_set, decode word killed with it
  task automatic redirect(input pc_mux_e mux, input exc_pc_mux_e exc);
    pc_mux_i = mux;
    exc_pc_mux_i = exc;
    pc_set_i = 1'b1;
    clear_instr_valid_i = 1'b1;
    next_cycle();
    pc_set_i = 1'b0;
    clear_instr_valid_i = 1'b0;
  endtask

  // run until n more loads, with random decode back-pressure in percent
  task automatic run_loads(input int n, input int ready_low_pct, input int halt_pct);
    int goal;
    goal = loads + n;
    while (loads < goal) begin
      id_ready_i = int'(next_rand() % 100) >= ready_low_pct;
      halt_if_i  = int'(next_rand() % 100) < halt_pct;
      next_cycle();
    end
    id_ready_i = 1'b1;
    halt_if_i = 1'b0;
  endtask

  task automatic set_slow_mem(input logic v);
    @(negedge clk);
    slow_mem = v;  // memory reads it after the next edge only
    next_cycle();
  endtask

  //////////////////////////////
  // memory model
  //////////////////////////////

  initial begin
    logic        acc, rv;
    logic [31:0] acc_addr;
    mem_rng = 32'd93739 ^ 32'h5bd1_e995;  // own stream from the same seed
    imem_rsp_i = '0;
    forever begin
      @(negedge clk);  // handshake is stable mid cycle
      acc = imem_req_o.req & imem_rsp_i.gnt;
      acc_addr = imem_req_o.addr;
      rv = imem_rsp_i.rvalid;
      @(posedge clk);
      #(DRV);
      if (!rst_n) begin
        pend.delete();
        imem_rsp_i = '0;
      end else begin
        if (rv) void'(pend.pop_front());  // head was taken at the edge
        if (acc) pend.push_back(acc_addr);
        check("outstanding within limit", 1, 32'(pend.size() <= `FETCH_MAX_OUTSTANDING));
        mem_rng = xorshift32(mem_rng);
        imem_rsp_i.gnt = slow_mem ? mem_rng[2] : (mem_rng[1:0] != 2'b00);
        imem_rsp_i.rvalid = (pend.size() != 0) &&
                            (slow_mem ? (mem_rng[6:5] == 2'b00) : (mem_rng[4:3] != 2'b00));
        imem_rsp_i.rdata = 32'h0;
        if (imem_rsp_i.rvalid) imem_rsp_i.rdata = ref_word(pend[0]);  // in order
      end
    end
  end

  //////////////////////////////
  // IF/ID monitor
  //////////////////////////////

  // predicts each edge's effect from mid cycle inputs, checks it one cycle later
  initial begin
    logic        fetching, pred_load, pred_clr, grant;
    logic [31:0] exp_pc;
    if_id_t      held;
    int          avail;  // words the queue should hold
    int          stale;  // responses still owed to a dropped stream
    forever begin
      @(negedge clk);
      if (!rst_n) begin
        fetching = 1'b0;
        pred_load = 1'b0;
        pred_clr = 1'b0;
        avail = 0;
        stale = 0;
        held = if_id_o;
      end else begin
        if (pred_load) begin
          check("valid", 1, 32'(if_id_o.valid));
          check("pc", exp_pc, if_id_o.pc);
          check("instr", ref_word(exp_pc), if_id_o.instr);
          exp_pc = exp_pc + 32'd4;
          loads++;
        end else if (pred_clr) begin
          check("valid after clear", 0, 32'(if_id_o.valid));
        end else begin
          check("if/id held", 1, 32'(if_id_o === held));  // stall keeps everything
        end
        held = if_id_o;
        // decode starves exactly when the queue is empty
        check("imiss", 32'(fetching && (avail == 0)), 32'(perf_imiss_o));
        if (pc_set_i) exp_pc = redirect_target(pc_mux_i, exc_pc_mux_i);
        // a load needs a word in the queue
        pred_load = fetching & id_ready_i & ~halt_if_i & ~pc_set_i & (avail != 0);
        pred_clr = clear_instr_valid_i;
        grant = imem_req_o.req & imem_rsp_i.gnt;
        if (pc_set_i) begin
          avail = 0;  // queue flushed
          stale = pend.size() + int'(grant) - int'(imem_rsp_i.rvalid);  // old stream in flight
        end else begin
          if (imem_rsp_i.rvalid) begin
            if (stale != 0) begin
              stale--;
            end else begin
              avail++;
            end
          end
          if (pred_load) avail--;
        end
        if (req_i | pc_set_i) fetching = 1'b1;
      end
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout: test %s made no progress within %0d cycles", cur_test, TIMEOUT_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

  //////////////////////////////
  // tests
  //////////////////////////////

  initial begin
    rst_n = 1'b0;
    req_i = 1'b0;
    pc_set_i = 1'b0;
    halt_if_i = 1'b0;
    id_ready_i = 1'b1;
    clear_instr_valid_i = 1'b0;
    pc_mux_i = PC_BOOT;
    exc_pc_mux_i = EXC_PC_EXCEPTION;
    boot_addr_i = 32'h0000_0080;
    trap_base_addr_i = 24'h000100;
    irq_id_i = '0;
    dm_halt_addr_i = 30'h0000_0200;
    jump_target_id_i = '0;
    jump_target_ex_i = '0;
    mepc_i = '0;
    depc_i = '0;
    repeat (10) @(posedge clk);
    #(DRV / 2) rst_n = 1'b1;  // ahead of the memory model's drive point
    next_cycle();

    begin_test("boot_stream");
    req_i = 1'b1;
    redirect(PC_BOOT, EXC_PC_EXCEPTION);
    run_loads(40, 0, 0);
    end_test();

    begin_test("redirect_in_flight");
    for (int i = 0; i < 8; i++) begin
      run_loads(3 + int'(next_rand() % 4), 0, 0);  // stream is mid flight here
      jump_target_id_i = next_rand();
      jump_target_ex_i = next_rand();
      redirect((next_rand() % 2 == 0) ? PC_JUMP : PC_BRANCH, EXC_PC_EXCEPTION);
      if (i == 3) begin
        jump_target_id_i = next_rand();
        redirect(PC_JUMP, EXC_PC_EXCEPTION);  // back to back redirects
      end
    end
    run_loads(6, 0, 0);
    end_test();

    begin_test("trap_targets");
    for (int i = 0; i < 5; i++) begin
      trap_base_addr_i = 24'(next_rand());
      irq_id_i = 5'(next_rand());
      dm_halt_addr_i = 30'(next_rand());
      mepc_i = next_rand();  // random low bits too
      depc_i = next_rand();
      case (i)
        0:       redirect(PC_EXCEPTION, EXC_PC_EXCEPTION);
        1:       redirect(PC_EXCEPTION, EXC_PC_IRQ);
        2:       redirect(PC_EXCEPTION, EXC_PC_DBD);
        3:       redirect(PC_MRET, EXC_PC_EXCEPTION);
        default: redirect(PC_DRET, EXC_PC_EXCEPTION);
      endcase
      run_loads(6, 0, 0);
    end
    end_test();

    begin_test("decode_stall");
    run_loads(40, 30, 20);
    end_test();

    begin_test("credit_limit");
    set_slow_mem(1'b1);
    run_loads(10, 0, 0);
    id_ready_i = 1'b0;  // long stall, queue fills and credits run out
    repeat (STALL) next_cycle();
    @(negedge clk);
    check("req low when out of credit", 0, 32'(imem_req_o.req));
    check("nothing in flight", 0, 32'(if_busy_o));
    next_cycle();
    id_ready_i = 1'b1;
    run_loads(20, 20, 10);
    set_slow_mem(1'b0);
    end_test();

    $display("%0d checks, %0d errors, %0d loads", checks, errors, loads);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- fetch_if_stage.sv
`include "fetch_params.svh"

// instruction fetch stage top
module fetch_if_stage (
  input  logic                        clk,
  input  logic                        rst_n,
  // control from the controller
  input  logic                        req_i,
  input  logic                        pc_set_i,
  input  fetch_ctrl_pkg::pc_mux_e     pc_mux_i,
  input  fetch_ctrl_pkg::exc_pc_mux_e exc_pc_mux_i,
  input  logic                        halt_if_i,
  input  logic                        id_ready_i,
  input  logic                        clear_instr_valid_i,
  // redirect address sources
  input  logic [`FETCH_ADDR_W-1:0]    boot_addr_i,
  input  logic [23:0]                 trap_base_addr_i,
  input  logic [4:0]                  irq_id_i,
  input  logic [29:0]                 dm_halt_addr_i,
  input  logic [`FETCH_ADDR_W-1:0]    jump_target_id_i,
  input  logic [`FETCH_ADDR_W-1:0]    jump_target_ex_i,
  input  logic [`FETCH_ADDR_W-1:0]    mepc_i,
  input  logic [`FETCH_ADDR_W-1:0]    depc_i,
  // instruction memory
  output fetch_bus_pkg::fetch_req_t   imem_req_o,
  input  fetch_bus_pkg::fetch_rsp_t   imem_rsp_i,
  // to decode
  output fetch_ctrl_pkg::if_id_t      if_id_o,
  output logic                        if_busy_o,
  output logic                        perf_imiss_o
);

  logic [`FETCH_ADDR_W-1:0]               target;
  logic                                   credit, drop_rsp, flush, pop, push;
  logic                                   fifo_empty;
  logic [31:0]                            fifo_data;
  logic [$clog2(`FETCH_FIFO_DEPTH+1)-1:0] fifo_count;

  assign push = imem_rsp_i.rvalid & ~drop_rsp;  // stale words never land

  fetch_pc_sel u_pc_sel (
    .pc_mux_i, .exc_pc_mux_i, .boot_addr_i, .trap_base_addr_i, .irq_id_i, .dm_halt_addr_i,
    .jump_target_id_i, .jump_target_ex_i, .mepc_i, .depc_i,
    .target_o (target)
  );

  fetch_credit_ctr u_credit_ctr (
    .clk, .rst_n,
    .grant_i      (imem_req_o.req & imem_rsp_i.gnt),
    .rvalid_i     (imem_rsp_i.rvalid),
    .flush_i      (flush),
    .fifo_count_i (fifo_count),
    .credit_o     (credit),
    .drop_rsp_o   (drop_rsp),
    .busy_o       (if_busy_o)  // busy while any response is owed
  );

  fetch_prefetch_fifo u_prefetch_fifo (
    .clk, .rst_n,
    .flush_i (flush), .push_i (push), .push_data_i (imem_rsp_i.rdata), .pop_i (pop),
    .pop_data_o (fifo_data), .empty_o (fifo_empty), .count_o (fifo_count)
  );

  fetch_ctrl_fsm u_ctrl_fsm (
    .clk, .rst_n, .req_i, .pc_set_i,
    .target_i (target), .credit_i (credit), .gnt_i (imem_rsp_i.gnt),
    .fifo_empty_i (fifo_empty), .fifo_data_i (fifo_data),
    .halt_if_i, .id_ready_i, .clear_instr_valid_i,
    .imem_req_o, .flush_o (flush), .pop_o (pop), .if_id_o, .perf_imiss_o
  );

endmodule

//--- fetch_ctrl_fsm.sv
`include "fetch_params.svh"

// fetch control: request address, request strobe, queue pop and IF/ID register
module fetch_ctrl_fsm (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       req_i,                // core wants instructions
  input  logic                       pc_set_i,             // redirect
  input  logic [`FETCH_ADDR_W-1:0]   target_i,             // from fetch_pc_sel
  input  logic                       credit_i,
  input  logic                       gnt_i,
  input  logic                       fifo_empty_i,
  input  logic [31:0]                fifo_data_i,
  input  logic                       halt_if_i,
  input  logic                       id_ready_i,
  input  logic                       clear_instr_valid_i,
  output fetch_bus_pkg::fetch_req_t  imem_req_o,
  output logic                       flush_o,
  output logic                       pop_o,
  output fetch_ctrl_pkg::if_id_t     if_id_o,
  output logic                       perf_imiss_o
);
  import fetch_bus_pkg::*;
  import fetch_ctrl_pkg::*;

  localparam logic [`FETCH_ADDR_W-1:0] WORD_STEP = 4;

  typedef enum logic {IDLE, FETCH} state_e;

  state_e                   state_q;
  logic [`FETCH_ADDR_W-1:0] addr_q;   // address of the next request
  logic [`FETCH_ADDR_W-1:0] pc_q;     // pc of the word at the queue head
  logic                     pend_q;   // shown to memory last cycle without gnt
  logic                     start;    // leaving IDLE
  logic                     accept;   // request taken by memory
  logic                     load;     // queue head goes into IF/ID
  logic                     valid_q;
  logic [31:0]              instr_q;
  logic [`FETCH_ADDR_W-1:0] pc_id_q;
  fetch_req_t               req;
  if_id_t                   if_id;

  assign start = (state_q == IDLE) & (req_i | pc_set_i);

  // pend_q keeps a shown request alive even if req_i falls
  assign req.req  = (state_q == FETCH) & credit_i & (req_i | pend_q);
  assign req.addr = addr_q;
  assign accept   = req.req & gnt_i;

  assign load = (state_q == FETCH) & ~fifo_empty_i & id_ready_i & ~halt_if_i & ~pc_set_i;

  assign imem_req_o   = req;
  assign flush_o      = pc_set_i;  // queue and stale responses go on redirect
  assign pop_o        = load;
  assign perf_imiss_o = (state_q == FETCH) & fifo_empty_i;  // decode starved

  //////////////////////////////
  // state, addresses
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      addr_q  <= '0;
      pc_q    <= '0;
      pend_q  <= 1'b0;
    end else begin
      if (start) state_q <= FETCH;  // stays fetching from here on
      pend_q <= req.req & ~gnt_i;
      if (start || pc_set_i) begin
        addr_q <= target_i;  // boot target on the first start
        pc_q   <= target_i;
      end else begin
        if (accept) addr_q <= addr_q + WORD_STEP;
        if (load)   pc_q   <= pc_q + WORD_STEP;
      end
    end
  end

  //////////////////////////////
  // IF/ID register
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (clear_instr_valid_i) begin
      valid_q <= 1'b0;  // controller kills the word in decode
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      instr_q <= fifo_data_i;
      pc_id_q <= pc_q;
    end
  end

  assign if_id.valid = valid_q;
  assign if_id.instr = instr_q;
  assign if_id.pc    = pc_id_q;
  assign if_id_o     = if_id;

  // bus rule, a redirect is the only thing allowed to move a waiting request
  a_req_stable : assert property (@(posedge clk) disable iff (!rst_n)
    req.req && !gnt_i && !pc_set_i |=> req.req && $stable(req.addr));

endmodule

//--- fetch_prefetch_fifo.sv
`include "fetch_params.svh"

// circular prefetch queue between memory responses and the IF/ID register
module fetch_prefetch_fifo (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   flush_i,      // drop everything
  input  logic                                   push_i,
  input  logic [31:0]                            push_data_i,
  input  logic                                   pop_i,
  output logic [31:0]                            pop_data_o,   // head word, valid when !empty_o
  output logic                                   empty_o,
  output logic [$clog2(`FETCH_FIFO_DEPTH+1)-1:0] count_o
);

  localparam int DEPTH = `FETCH_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [31:0]      mem_q [DEPTH];   // word storage
  logic [PTR_W-1:0] rptr_q, wptr_q;  // head and tail
  logic [CNT_W-1:0] cnt_q;           // occupancy
  logic             push_en, pop_en;

  // wrap for any depth, not only powers of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (int'(p) == DEPTH - 1) ? '0 : p + PTR_W'(1);
  endfunction

  assign push_en = push_i & ~flush_i;            // flush wins over push
  assign pop_en  = pop_i & ~flush_i & ~empty_o;  // never pop air

  assign empty_o    = (cnt_q == '0);
  assign count_o    = cnt_q;
  assign pop_data_o = mem_q[rptr_q];

  ////////////////////////////////
  // pointers and count
  ////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rptr_q <= '0;
      wptr_q <= '0;
      cnt_q  <= '0;
    end else if (flush_i) begin
      rptr_q <= '0;  // empty in one cycle
      wptr_q <= '0;
      cnt_q  <= '0;
    end else begin
      if (push_en) wptr_q <= ptr_inc(wptr_q);
      if (pop_en)  rptr_q <= ptr_inc(rptr_q);
      case ({push_en, pop_en})
        2'b10:   cnt_q <= cnt_q + CNT_W'(1);
        2'b01:   cnt_q <= cnt_q - CNT_W'(1);
        default: cnt_q <= cnt_q;  // both or neither
      endcase
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (push_en) mem_q[wptr_q] <= push_data_i;
  end

  // credits reserve a slot before the request leaves, so a full push is a bug upstream
  a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n)
    push_i |-> (int'(cnt_q) < DEPTH));

endmodule

//--- fetch_credit_ctr.sv
`include "fetch_params.svh"

// tracks requests in flight and grants new ones only when a slot is reserved
module fetch_credit_ctr (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic                                     grant_i,       // req & gnt
  input  logic                                     rvalid_i,      // response this cycle
  input  logic                                     flush_i,       // redirect, old stream dies
  input  logic [$clog2(`FETCH_FIFO_DEPTH+1)-1:0]   fifo_count_i,  // words already queued
  output logic                                     credit_o,      // a new request fits
  output logic                                     drop_rsp_o,    // this rvalid is stale
  output logic                                     busy_o         // something still in flight
);

  localparam int OUT_W = $clog2(`FETCH_MAX_OUTSTANDING + 1);

  logic [OUT_W-1:0] out_q, out_d;    // granted minus answered
  logic [OUT_W-1:0] disc_q, disc_d;  // part of out_q that belongs to a flushed stream

  assign drop_rsp_o = rvalid_i & (disc_q != '0);  // oldest responses are the stale ones
  assign busy_o     = (out_q != '0);

  // every outstanding word owns a queue slot, discarded ones too until they arrive
  assign credit_o = ((int'(fifo_count_i) + int'(out_q)) < `FETCH_FIFO_DEPTH) &&
                    (int'(out_q) < `FETCH_MAX_OUTSTANDING);

  always_comb begin
    out_d = out_q;
    if (grant_i && !rvalid_i) begin
      out_d = out_q + OUT_W'(1);
    end else if (!grant_i && rvalid_i) begin
      out_d = out_q - OUT_W'(1);
    end

    disc_d = disc_q;
    if (flush_i) begin
      disc_d = out_d;  // a grant in the flush cycle still carries the old address
    end else if (drop_rsp_o) begin
      disc_d = disc_q - OUT_W'(1);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_q  <= '0;
      disc_q <= '0;
    end else begin
      out_q  <= out_d;
      disc_q <= disc_d;
    end
  end

  // memory answers only what it granted, in order
  a_no_orphan_rsp : assert property (@(posedge clk) disable iff (!rst_n)
    rvalid_i |-> (out_q != '0));

  // fsm must respect credit_o
  a_out_bound : assert property (@(posedge clk) disable iff (!rst_n)
    int'(out_q) <= `FETCH_MAX_OUTSTANDING);

endmodule

//--- fetch_pc_sel.sv
`include "fetch_params.svh"

// next fetch address on a redirect, purely combinational
module fetch_pc_sel (
  input  fetch_ctrl_pkg::pc_mux_e     pc_mux_i,
  input  fetch_ctrl_pkg::exc_pc_mux_e exc_pc_mux_i,
  input  logic [`FETCH_ADDR_W-1:0]    boot_addr_i,
  input  logic [23:0]                 trap_base_addr_i,  // mtvec upper bits
  input  logic [4:0]                  irq_id_i,          // vector index
  input  logic [29:0]                 dm_halt_addr_i,    // word address of debug rom entry
  input  logic [`FETCH_ADDR_W-1:0]    jump_target_id_i,
  input  logic [`FETCH_ADDR_W-1:0]    jump_target_ex_i,
  input  logic [`FETCH_ADDR_W-1:0]    mepc_i,
  input  logic [`FETCH_ADDR_W-1:0]    depc_i,
  output logic [`FETCH_ADDR_W-1:0]    target_o
);
  import fetch_ctrl_pkg::*;

  logic [`FETCH_ADDR_W-1:0] exc_pc;  // trap entry
  logic [`FETCH_ADDR_W-1:0] raw_pc;  // selected target before alignment

  //////////////////////////////
  // trap entry address
  //////////////////////////////

  always_comb begin
    case (exc_pc_mux_i)
      EXC_PC_EXCEPTION: exc_pc = {trap_base_addr_i, 8'h00};  // all sync traps share one entry
      EXC_PC_IRQ:       exc_pc = {trap_base_addr_i, 1'b0, irq_id_i, 2'b00};  // 4 bytes per vector
      EXC_PC_DBD:       exc_pc = {dm_halt_addr_i, 2'b00};
      default:          exc_pc = {trap_base_addr_i, 8'h00};
    endcase
  end

  //////////////////////////////
  // redirect target
  //////////////////////////////

  always_comb begin
    case (pc_mux_i)
      PC_BOOT:      raw_pc = boot_addr_i;
      PC_JUMP:      raw_pc = jump_target_id_i;  // resolved in decode
      PC_BRANCH:    raw_pc = jump_target_ex_i;  // resolved in execute
      PC_EXCEPTION: raw_pc = exc_pc;
      PC_MRET:      raw_pc = mepc_i;
      PC_DRET:      raw_pc = depc_i;
      default:      raw_pc = boot_addr_i;
    endcase
  end

  // only word fetches here, low bits never reach memory
  assign target_o = {raw_pc[`FETCH_ADDR_W-1:2], 2'b00};

  // controller must never hand over an encoding outside the enums
  always_comb begin
    if (!$isunknown({pc_mux_i, exc_pc_mux_i})) begin
      a_legal_sel : assert (pc_mux_i inside {PC_BOOT, PC_JUMP, PC_BRANCH, PC_EXCEPTION,
                                             PC_MRET, PC_DRET} &&
                            exc_pc_mux_i inside {EXC_PC_EXCEPTION, EXC_PC_IRQ, EXC_PC_DBD})
        else $error("fetch_pc_sel: illegal selector pc_mux=%0d exc=%0d",
                    pc_mux_i, exc_pc_mux_i);
    end
  end

endmodule

//--- fetch_ctrl_pkg.sv
`include "fetch_params.svh"

// controller side of the fetch stage
package fetch_ctrl_pkg;

  //////////////////////////////
  // redirect selectors
  //////////////////////////////

  // source of the new pc on pc_set
  typedef enum logic [2:0] {
    PC_BOOT      = 3'd0,  // boot address
    PC_JUMP      = 3'd1,  // jal / jalr from decode
    PC_BRANCH    = 3'd2,  // taken branch from execute
    PC_EXCEPTION = 3'd3,  // trap entry, see exc_pc_mux_e
    PC_MRET      = 3'd4,  // back to mepc
    PC_DRET      = 3'd5   // back to depc
  } pc_mux_e;

  // which trap entry address to use
  typedef enum logic [1:0] {
    EXC_PC_EXCEPTION = 2'd0,  // common trap base
    EXC_PC_IRQ       = 2'd1,  // vectored by irq id
    EXC_PC_DBD       = 2'd2   // debug halt entry
  } exc_pc_mux_e;

  //////////////////////////////
  // IF/ID register
  //////////////////////////////

  typedef struct packed {
    logic                     valid;  // instr and pc hold a fetched word
    logic [31:0]              instr;  // raw instruction
    logic [`FETCH_ADDR_W-1:0] pc;     // address it came from
  } if_id_t;

endpackage

//--- fetch_bus_pkg.sv
`include "fetch_params.svh"

// instruction memory side of the fetch stage
package fetch_bus_pkg;

  //////////////////////////////
  // request channel
  //////////////////////////////

  // req and addr stay put until gnt is seen
  typedef struct packed {
    logic                     req;   // request strobe
    logic [`FETCH_ADDR_W-1:0] addr;  // word aligned fetch address
  } fetch_req_t;

  //////////////////////////////
  // response channel
  //////////////////////////////

  // rvalid comes back in order, one per granted request
  typedef struct packed {
    logic        gnt;     // request accepted this cycle
    logic        rvalid;  // rdata holds the oldest pending word
    logic [31:0] rdata;   // instruction word
  } fetch_rsp_t;

endpackage

//--- fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

//////////////////////////////
// fetch stage sizing
//////////////////////////////

// byte address width of the instruction port
`define FETCH_ADDR_W 32

// prefetch queue slots, also the credit pool
`define FETCH_FIFO_DEPTH 4

// granted requests that may wait for rvalid at once
// kept equal to the queue depth so every response has a slot
`define FETCH_MAX_OUTSTANDING `FETCH_FIFO_DEPTH

`endif
